// ==== rv32Core.f ====
+incdir+include
source/isaPkg.sv
source/corePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/intAlu.sv
source/pcUnit.sv
source/memWriteback.sv
source/rv32Core.sv
tb/rv32CoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv32CoreTb -f rv32Core.f \
    -o rv32CoreSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv32CoreSim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== tb/rv32CoreTb.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module rv32CoreTb;

    localparam logic [11:0] CHECK_ADDR = 12'h100;  // scratch address for result stores

    logic             clk;
    logic             rst;
    isaPkg::instrU    instr;
    logic [`XLEN-1:0] dataI;
    logic [`XLEN-1:0] instrAddr;
    corePkg::memReqT  memReq;
    logic [`XLEN-1:0] dataO;

    logic [31:0] lfsr;
    logic [31:0] expPc;   // fetch address expected in the next cycle
    logic [31:0] curPc;
    int          checkCount;
    int          errorCount;

    rv32Core rv32Core_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .dataI     (dataI),
        .instrAddr (instrAddr),
        .memReq    (memReq),
        .dataO     (dataO)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // random source and instruction encoders
    // ----------------------------------------
    function automatic logic lfsrStep();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsrStep()};
        end
        return r;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isaPkg::OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], isaPkg::STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isaPkg::BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isaPkg::JAL};
    endfunction

    // ----------------------------------------
    // reference rules
    // ----------------------------------------
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic corePkg::memWidthT widthOf(input int k);
        case (k % 3)
            0:       return corePkg::MEM_BYTE;
            1:       return corePkg::MEM_HALF;
            default: return corePkg::MEM_WORD;
        endcase
    endfunction

    // ----------------------------------------
    // drive and check
    // ----------------------------------------
    task automatic checkValue(input string what, input logic [31:0] got, exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one instruction per cycle, outputs settle 1 ns after the falling edge
    task automatic runInstr(input logic [31:0] word, input logic [31:0] loadData);
        @(negedge clk);
        instr = word;
        dataI = loadData;
        #1;
        curPc = instrAddr;
        checkValue("fetch address", instrAddr, expPc);
        expPc = instrAddr + 32'd4;
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;  // addi sign-extends the low part
        runInstr(encU(upper[31:12], rd, isaPkg::LUI), '0);
        runInstr(encI(value[11:0], rd, isaPkg::F3_ADD_SUB, rd, isaPkg::OP_IMM), '0);
    endtask

    task automatic storeCheck(input logic [4:0] rs, input logic [31:0] exp, input string what);
        runInstr(encS(CHECK_ADDR, rs, 5'd0, isaPkg::F3_SW), '0);
        checkValue({what, " store enable"}, {31'b0, memReq.wr}, 32'd1);
        checkValue({what, " store address"}, memReq.addr, {20'b0, CHECK_ADDR});
        checkValue(what, dataO, exp);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic resetDut();
        rst   = 1'b1;
        instr = encS(CHECK_ADDR, 5'd1, 5'd0, isaPkg::F3_SW);  // must stay off the bus
        dataI = '0;
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            #1;
            checkValue("request during reset", {30'b0, memReq.rd, memReq.wr}, 32'd0);
        end
        @(negedge clk);
        rst   = 1'b0;
        instr = '0;
        #1;
        checkValue("fetch address after reset", instrAddr, `RESET_VECTOR);
        checkValue("request after reset", {30'b0, memReq.rd, memReq.wr}, 32'd0);
        curPc = instrAddr;
        expPc = instrAddr + 32'd4;
    endtask

    task automatic testIllegal();
        logic [31:0] value;
        logic [31:0] bad [3];
        value  = randBits(32);
        bad[0] = 32'h0000_0000;
        bad[1] = 32'h0000_0280;  // opcode 0 with rd = x5
        bad[2] = encR(7'b1111111, 5'd2, 5'd1, isaPkg::F3_ADD_SUB, 5'd5);
        loadReg(5'd5, value);
        for (int k = 0; k < 3; k++) begin
            runInstr(bad[k], '0);
            checkValue("illegal request", {30'b0, memReq.rd, memReq.wr}, 32'd0);
        end
        storeCheck(5'd5, value, "x5 after illegal");
    endtask

    task automatic testAlu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tmp;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic        alt;
        for (int round = 0; round < 3; round++) begin
            a = randBits(32);
            b = randBits(32);
            loadReg(5'd1, a);
            loadReg(5'd2, b);
            for (int k = 0; k < 10; k++) begin
                f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);  // then SUB, SRA
                alt = k >= 8;
                runInstr(encR(alt ? isaPkg::F7_ALT : isaPkg::F7_BASE, 5'd2, 5'd1, f3, 5'd3),
                         '0);
                storeCheck(5'd3, aluModel(f3, alt, a, b), $sformatf("R-type f3 %0d", f3));
                if (k != 8) begin  // no SUBI
                    tmp = randBits(12);
                    if (f3 == isaPkg::F3_SLL || f3 == isaPkg::F3_SRL_SRA) begin
                        imm12 = {alt ? isaPkg::F7_ALT : isaPkg::F7_BASE, tmp[4:0]};
                    end else begin
                        imm12 = tmp[11:0];
                    end
                    runInstr(encI(imm12, 5'd1, f3, 5'd4, isaPkg::OP_IMM), '0);
                    storeCheck(5'd4, aluModel(f3, alt, a, {{20{imm12[11]}}, imm12}),
                               $sformatf("I-type f3 %0d", f3));
                end
            end
        end
        runInstr(encR(isaPkg::F7_BASE, 5'd2, 5'd1, isaPkg::F3_ADD_SUB, 5'd0), '0);
        storeCheck(5'd0, 32'd0, "x0");
    endtask

    task automatic testMem();
        logic [31:0] base;
        logic [31:0] val;
        logic [31:0] ld;
        logic [31:0] tmp;
        logic [2:0]  f3;
        base = randBits(32);
        val  = randBits(32);
        loadReg(5'd1, base);
        loadReg(5'd2, val);
        for (int k = 0; k < 3; k++) begin  // SB, SH, SW
            tmp = randBits(12);
            runInstr(encS(tmp[11:0], 5'd2, 5'd1, k[2:0]), '0);
            checkValue("store rd/wr", {30'b0, memReq.rd, memReq.wr}, 32'd1);
            checkValue("store width/sign", {29'b0, memReq.width, memReq.isUnsigned},
                       {29'b0, widthOf(k), 1'b0});
            checkValue("store address", memReq.addr, base + {{20{tmp[11]}}, tmp[11:0]});
            checkValue("store data", dataO, val);
        end
        for (int k = 0; k < 5; k++) begin  // LB, LH, LW, LBU, LHU
            f3  = (k < 3) ? k[2:0] : k[2:0] + 3'd1;
            tmp = randBits(12);
            ld  = randBits(32);
            runInstr(encI(tmp[11:0], 5'd1, f3, 5'd6, isaPkg::LOAD), ld);
            checkValue("load rd/wr", {30'b0, memReq.rd, memReq.wr}, 32'd2);
            checkValue("load width/sign", {29'b0, memReq.width, memReq.isUnsigned},
                       {29'b0, widthOf(k), k >= 3});
            checkValue("load address", memReq.addr, base + {{20{tmp[11]}}, tmp[11:0]});
            storeCheck(5'd6, ld, "load write-back");
        end
    endtask

    task automatic testBranch();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] tmp;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        a = randBits(32) | 32'h8000_0000;  // negative, large unsigned
        b = randBits(32) & 32'h7fff_ffff;
        loadReg(5'd1, a);
        loadReg(5'd2, b);
        loadReg(5'd3, a);
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
            // operand pairs (x1,x2) (x2,x1) (x1,x3) give each branch both outcomes
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                tmp = randBits(10);
                imm = {{20{tmp[9]}}, tmp[9:0], 2'b00};
                runInstr(encB(imm[12:0], rs2, rs1, f3), '0);
                if (branchModel(f3, (rs1 == 5'd2) ? b : a, (rs2 == 5'd2) ? b : a)) begin
                    expPc = curPc + imm;
                end
            end
        end
    endtask

    task automatic testJump();
        logic [31:0] tmp;
        logic [31:0] imm;
        logic [31:0] base;
        logic [31:0] link;
        tmp = randBits(16);
        imm = {{14{tmp[15]}}, tmp[15:0], 2'b00};
        runInstr(encJ(imm[20:0], 5'd5), '0);
        link  = curPc + 32'd4;
        expPc = curPc + imm;
        storeCheck(5'd5, link, "JAL link");

        tmp  = randBits(30);
        base = {tmp[29:0], 2'b00};
        loadReg(5'd6, base);
        tmp = randBits(10);
        imm = {{20{tmp[9]}}, tmp[9:0], 2'b01};  // odd offset, bit 0 is dropped
        runInstr(encI(imm[11:0], 5'd6, 3'b000, 5'd7, isaPkg::JALR), '0);
        link  = curPc + 32'd4;
        expPc = (base + imm) & ~32'd1;
        storeCheck(5'd7, link, "JALR link");

        tmp = randBits(20);
        runInstr(encU(tmp[19:0], 5'd8, isaPkg::LUI), '0);
        storeCheck(5'd8, {tmp[19:0], 12'b0}, "LUI");
        tmp = randBits(20);
        runInstr(encU(tmp[19:0], 5'd9, isaPkg::AUIPC), '0);
        storeCheck(5'd9, curPc + {tmp[19:0], 12'b0}, "AUIPC");
    endtask

    initial begin
        lfsr       = 32'hbb31bdb3;
        checkCount = 0;
        errorCount = 0;
        expPc      = `RESET_VECTOR;
        curPc      = '0;
        resetDut();
        testIllegal();
        testAlu();
        testMem();
        testBranch();
        testJump();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== source/rv32Core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module rv32Core (
    input  logic             clk,
    input  logic             rst,
    input  isaPkg::instrU    instr,
    input  logic [`XLEN-1:0] dataI,
    output logic [`XLEN-1:0] instrAddr,
    output corePkg::memReqT  memReq,
    output logic [`XLEN-1:0] dataO
);

    corePkg::ctrlT    ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] rdData;
    logic             regWe;

    assign instrAddr = pc;  // fetch is the current pc

    instrDecoder instrDecoder_i (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    // register indices sit at the same bits in every format
    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .we      (regWe),
        .rs1     (instr.r.rs1),
        .rs2     (instr.r.rs2),
        .rd      (instr.r.rd),
        .rdData  (rdData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    intAlu intAlu_i (
        .aluOp   (ctrl.aluOp),
        .srcAPc  (ctrl.srcAPc),
        .srcBImm (ctrl.srcBImm),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .imm     (imm),
        .result  (aluResult)
    );

    pcUnit pcUnit_i (
        .clk       (clk),
        .rst       (rst),
        .brCond    (ctrl.brCond),
        .jump      (ctrl.jump),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc)
    );

    memWriteback memWriteback_i (
        .rst       (rst),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .imm       (imm),
        .pc        (pc),
        .rs2Data   (rs2Data),
        .dataI     (dataI),
        .memReq    (memReq),
        .dataO     (dataO),
        .rdData    (rdData),
        .regWe     (regWe)
    );

endmodule

// ==== source/memWriteback.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module memWriteback (
    input  logic             rst,
    input  corePkg::ctrlT    ctrl,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] dataI,
    output corePkg::memReqT  memReq,
    output logic [`XLEN-1:0] dataO,
    output logic [`XLEN-1:0] rdData,
    output logic             regWe
);

    // ----------------------------------------
    // data-memory request
    // ----------------------------------------
    assign memReq.rd         = ctrl.memRead && !rst;
    assign memReq.wr         = ctrl.memWrite && !rst;
    assign memReq.width      = ctrl.memWidth;
    assign memReq.isUnsigned = ctrl.loadUnsigned;  // memory side does the extension
    assign memReq.addr       = aluResult;

    assign dataO = ctrl.memWrite ? rs2Data : '0;

    // ----------------------------------------
    // register write-back
    // ----------------------------------------
    always_comb begin
        case (ctrl.wbSel)
            corePkg::WB_LINK: rdData = pc + `XLEN'd4;
            corePkg::WB_IMM:  rdData = imm;
            corePkg::WB_LOAD: rdData = dataI;
            default:          rdData = aluResult;
        endcase
    end

    assign regWe = ctrl.regWrite && !rst;

endmodule

// ==== source/pcUnit.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module pcUnit (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::brCondT  brCond,
    input  corePkg::jumpT    jump,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] pc
);

    logic             eq;
    logic             lt;
    logic             ltu;
    logic             taken;
    logic [`XLEN-1:0] nextPc;

    // ----------------------------------------
    // branch compare
    // ----------------------------------------
    assign eq  = rs1Data == rs2Data;
    assign lt  = $signed(rs1Data) < $signed(rs2Data);
    assign ltu = rs1Data < rs2Data;

    always_comb begin
        case (brCond)
            corePkg::BR_EQ:  taken = eq;
            corePkg::BR_NE:  taken = !eq;
            corePkg::BR_LT:  taken = lt;
            corePkg::BR_GE:  taken = !lt;
            corePkg::BR_LTU: taken = ltu;
            corePkg::BR_GEU: taken = !ltu;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jump == corePkg::JMP_JALR) begin
            nextPc = {aluResult[`XLEN-1:1], 1'b0};
        end else if (taken || jump == corePkg::JMP_JAL) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_VECTOR;
        end else begin
            pc <= nextPc;
        end
    end

    // catches a misaligned JALR target or branch offset reaching fetch
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// ==== source/intAlu.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module intAlu (
    input  corePkg::aluOpT   aluOp,
    input  logic             srcAPc,
    input  logic             srcBImm,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;

    assign opA   = srcAPc  ? pc  : rs1Data;  // AUIPC
    assign opB   = srcBImm ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            corePkg::ALU_ADD:  result = opA + opB;
            corePkg::ALU_SUB:  result = opA - opB;
            corePkg::ALU_SLL:  result = opA << shamt;
            corePkg::ALU_SRL:  result = opA >> shamt;
            corePkg::ALU_SRA:  result = $signed(opA) >>> shamt;
            corePkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            corePkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, opA < opB};
            corePkg::ALU_AND:  result = opA & opB;
            corePkg::ALU_OR:   result = opA | opB;
            corePkg::ALU_XOR:  result = opA ^ opB;
            default:           result = '0;
        endcase
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [`REG_IDX_W-1:0] rs1,
    input  logic [`REG_IDX_W-1:0] rs2,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`XLEN-1:0]      rdData,
    output logic [`XLEN-1:0]      rs1Data,
    output logic [`XLEN-1:0]      rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 is never written, reads of it are forced to zero
    always_ff @(posedge clk) begin
        if (!rst && we && rd != '0) begin
            regs[rd] <= rdData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    // a write shows on the next read of that register
    assert property (@(posedge clk) disable iff (rst)
        (we && rd != '0) |=> (rs1 != $past(rd) || rs1Data == $past(rdData)))
        else $error("register write not seen on the next read");

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module instrDecoder (
    input  isaPkg::instrU    instr,
    output corePkg::ctrlT    ctrl,
    output logic [`XLEN-1:0] imm
);

    logic [2:0]     funct3;
    logic           f7Base;
    logic           f7Alt;
    logic           opLegal;
    logic           opImmLegal;
    corePkg::aluOpT aluSel;

    assign funct3 = instr.r.funct3;
    assign f7Base = instr.r.funct7 == isaPkg::F7_BASE;
    assign f7Alt  = instr.r.funct7 == isaPkg::F7_ALT;

    // only ADD/SUB and SRL/SRA have an alternate form
    assign opLegal = f7Base || (f7Alt && (funct3 == isaPkg::F3_ADD_SUB ||
                                          funct3 == isaPkg::F3_SRL_SRA));
    assign opImmLegal = (funct3 == isaPkg::F3_SLL)     ? f7Base :
                        (funct3 == isaPkg::F3_SRL_SRA) ? (f7Base || f7Alt) : 1'b1;

    always_comb begin
        case (funct3)
            isaPkg::F3_ADD_SUB: aluSel = (instr.r.opcode == isaPkg::OP && f7Alt) ?
                                         corePkg::ALU_SUB : corePkg::ALU_ADD;
            isaPkg::F3_SLL:     aluSel = corePkg::ALU_SLL;
            isaPkg::F3_SLT:     aluSel = corePkg::ALU_SLT;
            isaPkg::F3_SLTU:    aluSel = corePkg::ALU_SLTU;
            isaPkg::F3_XOR:     aluSel = corePkg::ALU_XOR;
            isaPkg::F3_SRL_SRA: aluSel = f7Alt ? corePkg::ALU_SRA : corePkg::ALU_SRL;
            isaPkg::F3_OR:      aluSel = corePkg::ALU_OR;
            default:            aluSel = corePkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;  // unknown encodings stay inactive
        imm  = '0;
        case (instr.r.opcode)
            isaPkg::OP: begin
                ctrl.aluOp    = aluSel;
                ctrl.regWrite = opLegal;
            end
            isaPkg::OP_IMM: begin
                imm           = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
                ctrl.aluOp    = aluSel;
                ctrl.srcBImm  = 1'b1;
                ctrl.regWrite = opImmLegal;
            end
            isaPkg::LOAD: begin
                imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
                if (funct3 inside {isaPkg::F3_LB, isaPkg::F3_LH, isaPkg::F3_LW,
                                   isaPkg::F3_LBU, isaPkg::F3_LHU}) begin
                    ctrl.srcBImm      = 1'b1;
                    ctrl.memRead      = 1'b1;
                    ctrl.memWidth     = corePkg::memWidthT'(funct3[1:0]);
                    ctrl.loadUnsigned = funct3[2];
                    ctrl.regWrite     = 1'b1;
                    ctrl.wbSel        = corePkg::WB_LOAD;
                end
            end
            isaPkg::STORE: begin
                imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
                if (funct3 inside {isaPkg::F3_SB, isaPkg::F3_SH, isaPkg::F3_SW}) begin
                    ctrl.srcBImm  = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.memWidth = corePkg::memWidthT'(funct3[1:0]);
                end
            end
            isaPkg::BRANCH: begin
                imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                       instr.b.imm4_1, 1'b0};
                case (funct3)
                    isaPkg::F3_BEQ:  ctrl.brCond = corePkg::BR_EQ;
                    isaPkg::F3_BNE:  ctrl.brCond = corePkg::BR_NE;
                    isaPkg::F3_BLT:  ctrl.brCond = corePkg::BR_LT;
                    isaPkg::F3_BGE:  ctrl.brCond = corePkg::BR_GE;
                    isaPkg::F3_BLTU: ctrl.brCond = corePkg::BR_LTU;
                    isaPkg::F3_BGEU: ctrl.brCond = corePkg::BR_GEU;
                    default:         ctrl.brCond = corePkg::BR_NONE;
                endcase
            end
            isaPkg::JAL: begin
                imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                       instr.j.imm10_1, 1'b0};
                ctrl.jump     = corePkg::JMP_JAL;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = corePkg::WB_LINK;
            end
            isaPkg::JALR: begin
                imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
                if (funct3 == 3'b000) begin
                    ctrl.srcBImm  = 1'b1;  // target comes from the alu add
                    ctrl.jump     = corePkg::JMP_JALR;
                    ctrl.regWrite = 1'b1;
                    ctrl.wbSel    = corePkg::WB_LINK;
                end
            end
            isaPkg::LUI: begin
                imm           = {instr.u.imm31_12, 12'b0};
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = corePkg::WB_IMM;
            end
            isaPkg::AUIPC: begin
                imm           = {instr.u.imm31_12, 12'b0};
                ctrl.srcAPc   = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/corePkg.sv ====
`include "core_defines.svh"

package corePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } brCondT;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jumpT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,  // pc+4
        WB_IMM,
        WB_LOAD
    } wbSelT;

    // same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } memWidthT;

    // ----------------------------------------
    // data-memory port
    // ----------------------------------------
    typedef struct packed {
        logic             rd;
        logic             wr;
        memWidthT         width;
        logic             isUnsigned;
        logic [`XLEN-1:0] addr;
    } memReqT;

    // per-instruction control, all zero is a no-op
    typedef struct packed {
        aluOpT    aluOp;
        logic     srcAPc;
        logic     srcBImm;
        brCondT   brCond;
        jumpT     jump;
        logic     regWrite;
        wbSelT    wbSel;
        logic     memRead;
        logic     memWrite;
        memWidthT memWidth;
        logic     loadUnsigned;
    } ctrlT;

endpackage

// ==== source/isaPkg.sv ====
package isaPkg;

    // ----------------------------------------
    // major opcodes, RV32I base set only
    // ----------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeT;

    // ----------------------------------------
    // instruction formats, msb first
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        opcodeT     opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcodeT      opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcodeT     opcode;
    } jTypeT;

    // one fetched word, viewed per format
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrU;

    // alu funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA/SRAI

endpackage

// ==== include/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN         32

// architectural register file
`define REG_COUNT    32
`define REG_IDX_W    5

`define RESET_VECTOR 32'h0000_0800  // first fetch address

`endif
